//--- logic/csr_pkg.sv
// machine-mode csr definitions for rv32i; addresses follow the privileged spec, mip is not implemented
package csr_pkg;

    // access and counter widths
    localparam int CSR_XLEN   = 32;  // one csr access
    localparam int CSR_ADDR_W = 12;  // csr index field of the instruction
    localparam int CNT_W      = 64;  // mcycle / minstret
    localparam int NUM_CNT    = 2;   // performance counters in the generate loop

    // counter indices, also bit positions in the write select and inhibit vectors
    localparam int CNT_CYCLE   = 0;
    localparam int CNT_INSTRET = 1;

    // funct3 of the zicsr instructions; 3'b000 and 3'b100 are no access
    typedef enum logic [2:0] {
        OP_RW  = 3'b001,  // read-write, rs1 source
        OP_RS  = 3'b010,  // read-set
        OP_RC  = 3'b011,  // read-clear
        OP_RWI = 3'b101,  // immediate variants
        OP_RSI = 3'b110,
        OP_RCI = 3'b111
    } csr_op_e;

    // machine information, all read zero
    localparam logic [CSR_ADDR_W-1:0] A_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] A_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] A_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] A_MHARTID   = 12'hF14;
    // machine trap setup
    localparam logic [CSR_ADDR_W-1:0] A_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] A_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] A_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] A_MTVEC     = 12'h305;
    // machine trap handling
    localparam logic [CSR_ADDR_W-1:0] A_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] A_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] A_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] A_MTVAL     = 12'h343;
    // machine counters, rv32 splits them in halves
    localparam logic [CSR_ADDR_W-1:0] A_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] A_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] A_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] A_MINSTRETH = 12'hB82;
    localparam logic [CSR_ADDR_W-1:0] A_MCOUNTINHIBIT = 12'h320;

    // one write select per writable config register
    typedef enum logic [2:0] {
        SEL_MSTATUS       = 3'd0,
        SEL_MIE           = 3'd1,
        SEL_MTVEC         = 3'd2,
        SEL_MSCRATCH      = 3'd3,
        SEL_MEPC          = 3'd4,
        SEL_MCAUSE        = 3'd5,
        SEL_MTVAL         = 3'd6,
        SEL_MCOUNTINHIBIT = 3'd7
    } cfg_sel_e;

    localparam int NUM_CFG_SEL = 8;  // entries of cfg_sel_e

    // mxl = 1 (32 bit) in [31:30], extension I at bit 8
    localparam logic [CSR_XLEN-1:0] MISA_VALUE = 32'h4000_0100;

endpackage

//--- logic/csr_access_decode.sv
// combinational; a write select rises only with i_csr_valid and a legal funct3, read-only csrs get none
module csr_access_decode (
    input  logic                          i_csr_valid,
    input  csr_pkg::csr_op_e              i_funct3,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] i_csr_index,
    input  logic [csr_pkg::CSR_XLEN-1:0]  i_rs1,
    input  logic [csr_pkg::CSR_XLEN-1:0]  i_imm,
    input  logic [csr_pkg::CSR_XLEN-1:0]  i_cur_data,   // old value of the indexed csr
    output logic [csr_pkg::NUM_CFG_SEL-1:0] o_cfg_wr_sel, // one-hot or zero
    output logic [csr_pkg::NUM_CNT-1:0]   o_cnt_wr_lo,
    output logic [csr_pkg::NUM_CNT-1:0]   o_cnt_wr_hi,
    output logic [csr_pkg::CSR_XLEN-1:0]  o_wr_data
);
    import csr_pkg::*;

    logic                op_legal;  // funct3 is one of the six zicsr ops
    logic                wr_en;
    logic [CSR_XLEN-1:0] src;       // rs1 or zero-extended immediate

    assign op_legal = i_funct3 inside {OP_RW, OP_RS, OP_RC, OP_RWI, OP_RSI, OP_RCI};
    assign wr_en    = i_csr_valid && op_legal;
    assign src      = i_funct3[2] ? i_imm : i_rs1; // bit 2 marks the immediate forms

    // new value from old value and source
    always_comb begin
        case (i_funct3)
            OP_RW, OP_RWI: o_wr_data = src;                 // replace
            OP_RS, OP_RSI: o_wr_data = i_cur_data | src;    // set bits
            OP_RC, OP_RCI: o_wr_data = i_cur_data & ~src;   // clear bits
            default:       o_wr_data = i_cur_data;          // no access, nothing stored
        endcase
    end

    // index to write select
    always_comb begin
        o_cfg_wr_sel = '0;
        o_cnt_wr_lo  = '0;
        o_cnt_wr_hi  = '0;
        if (wr_en) begin
            case (i_csr_index)
                A_MSTATUS:       o_cfg_wr_sel[SEL_MSTATUS]       = 1'b1;
                A_MIE:           o_cfg_wr_sel[SEL_MIE]           = 1'b1;
                A_MTVEC:         o_cfg_wr_sel[SEL_MTVEC]         = 1'b1;
                A_MSCRATCH:      o_cfg_wr_sel[SEL_MSCRATCH]      = 1'b1;
                A_MEPC:          o_cfg_wr_sel[SEL_MEPC]          = 1'b1;
                A_MCAUSE:        o_cfg_wr_sel[SEL_MCAUSE]        = 1'b1;
                A_MTVAL:         o_cfg_wr_sel[SEL_MTVAL]         = 1'b1;
                A_MCOUNTINHIBIT: o_cfg_wr_sel[SEL_MCOUNTINHIBIT] = 1'b1;
                A_MCYCLE:        o_cnt_wr_lo[CNT_CYCLE]          = 1'b1;
                A_MCYCLEH:       o_cnt_wr_hi[CNT_CYCLE]          = 1'b1;
                A_MINSTRET:      o_cnt_wr_lo[CNT_INSTRET]        = 1'b1;
                A_MINSTRETH:     o_cnt_wr_hi[CNT_INSTRET]        = 1'b1;
                default: ;  // misa, info regs and unknown indices ignore writes
            endcase
        end
    end

    // a single access never reaches two registers, across config and counter selects
    a_one_target: assert final ($onehot0({o_cfg_wr_sel, o_cnt_wr_lo, o_cnt_wr_hi}))
        else $error("csr decode drives more than one write select");

endmodule

//--- logic/csr_config_regs.sv
// writable mstatus/mie/mtvec/mscratch/mepc/mcause/mtval/mcountinhibit fields; only csr writes change them
module csr_config_regs #(
    parameter logic [csr_pkg::CSR_XLEN-1:0] TRAP_ADDRESS = '0  // mtvec after reset
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic [csr_pkg::NUM_CFG_SEL-1:0] i_cfg_wr_sel,
    input  logic [csr_pkg::CSR_XLEN-1:0]    i_wr_data,
    output logic                            o_mstatus_mie,
    output logic                            o_mstatus_mpie,
    output logic                            o_mie_msie,
    output logic                            o_mie_mtie,
    output logic                            o_mie_meie,
    output logic [csr_pkg::CSR_XLEN-1:0]    o_mtvec,
    output logic [csr_pkg::CSR_XLEN-1:0]    o_mscratch,
    output logic [csr_pkg::CSR_XLEN-1:0]    o_mepc,
    output logic [csr_pkg::CSR_XLEN-1:0]    o_mtval,
    output logic                            o_mcause_int,
    output logic [3:0]                      o_mcause_code,
    output logic [csr_pkg::NUM_CNT-1:0]     o_cnt_inhibit   // per counter, cy and ir
);
    import csr_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mstatus_mie  <= 1'b0;
            o_mstatus_mpie <= 1'b0;
            o_mie_msie     <= 1'b0;
            o_mie_mtie     <= 1'b0;
            o_mie_meie     <= 1'b0;
            o_mtvec        <= TRAP_ADDRESS;  // direct mode base unless the address says otherwise
            o_mscratch     <= '0;
            o_mepc         <= '0;
            o_mtval        <= '0;
            o_mcause_int   <= 1'b0;
            o_mcause_code  <= '0;
            o_cnt_inhibit  <= '0;            // both counters run
        end else begin
            // mstatus, only mie and mpie are writable, mpp stays machine mode
            if (i_cfg_wr_sel[SEL_MSTATUS]) begin
                o_mstatus_mie  <= i_wr_data[3];
                o_mstatus_mpie <= i_wr_data[7];
            end
            if (i_cfg_wr_sel[SEL_MIE]) begin
                o_mie_msie <= i_wr_data[3];   // software
                o_mie_mtie <= i_wr_data[7];   // timer
                o_mie_meie <= i_wr_data[11];  // external
            end
            if (i_cfg_wr_sel[SEL_MTVEC])
                o_mtvec <= i_wr_data;         // base and mode together
            if (i_cfg_wr_sel[SEL_MSCRATCH])
                o_mscratch <= i_wr_data;
            if (i_cfg_wr_sel[SEL_MEPC])
                o_mepc <= {i_wr_data[CSR_XLEN-1:2], 2'b00}; // word aligned, no C extension
            // mcause keeps the interrupt flag and a 4-bit code, the rest reads zero
            if (i_cfg_wr_sel[SEL_MCAUSE]) begin
                o_mcause_int  <= i_wr_data[31];
                o_mcause_code <= i_wr_data[3:0];
            end
            if (i_cfg_wr_sel[SEL_MTVAL])
                o_mtval <= i_wr_data;         // plain storage
            if (i_cfg_wr_sel[SEL_MCOUNTINHIBIT]) begin
                o_cnt_inhibit[CNT_CYCLE]   <= i_wr_data[0];  // cy
                o_cnt_inhibit[CNT_INSTRET] <= i_wr_data[2];  // ir
            end
        end
    end

    // mepc never holds a misaligned address, whatever was written
    a_mepc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mepc[1:0] == 2'b00)
        else $error("mepc holds a misaligned address");

endmodule

//--- logic/hpm_counter.sv
// 64-bit counter written in 32-bit halves; a half write wins over the increment in the same cycle
module hpm_counter (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_inc,      // count event this cycle
    input  logic                         i_inhibit,  // mcountinhibit bit
    input  logic                         i_wr_lo,
    input  logic                         i_wr_hi,
    input  logic [csr_pkg::CSR_XLEN-1:0] i_wr_data,
    output logic [csr_pkg::CNT_W-1:0]    o_count
);
    import csr_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_wr_lo || i_wr_hi) begin
            // the half not written holds
            if (i_wr_lo)
                o_count[CSR_XLEN-1:0] <= i_wr_data;
            if (i_wr_hi)
                o_count[CNT_W-1:CSR_XLEN] <= i_wr_data;
        end else if (i_inc && !i_inhibit) begin
            o_count <= o_count + 1'b1;  // wraps at 2^64
        end
    end

    // inhibited and not written, the count must not move
    a_inhibit_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_inhibit && !i_wr_lo && !i_wr_hi) |=> $stable(o_count))
        else $error("counter moved while inhibited");

endmodule

//--- logic/csr_read_mux.sv
// current value of the indexed csr; read data and valid are registered, unknown indices read zero
module csr_read_mux (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_csr_valid,
    input  csr_pkg::csr_op_e               i_funct3,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] i_csr_index,
    input  logic                           i_mstatus_mie,
    input  logic                           i_mstatus_mpie,
    input  logic                           i_mie_msie,
    input  logic                           i_mie_mtie,
    input  logic                           i_mie_meie,
    input  logic [csr_pkg::CSR_XLEN-1:0]   i_mtvec,
    input  logic [csr_pkg::CSR_XLEN-1:0]   i_mscratch,
    input  logic [csr_pkg::CSR_XLEN-1:0]   i_mepc,
    input  logic [csr_pkg::CSR_XLEN-1:0]   i_mtval,
    input  logic                           i_mcause_int,
    input  logic [3:0]                     i_mcause_code,
    input  logic [csr_pkg::NUM_CNT-1:0]    i_cnt_inhibit,
    input  logic [csr_pkg::CNT_W-1:0]      i_cnt_cycle,
    input  logic [csr_pkg::CNT_W-1:0]      i_cnt_instret,
    output logic [csr_pkg::CSR_XLEN-1:0]   o_cur_data,    // combinational, feeds the decoder
    output logic [csr_pkg::CSR_XLEN-1:0]   o_csr_rdata,   // old value, one cycle after the request
    output logic                           o_rdata_valid
);
    import csr_pkg::*;

    // word at architectural bit positions
    always_comb begin
        o_cur_data = '0;
        case (i_csr_index)
            A_MVENDORID, A_MARCHID, A_MIMPID, A_MHARTID: o_cur_data = '0;  // single hart, id 0
            A_MSTATUS: begin
                o_cur_data[3]     = i_mstatus_mie;
                o_cur_data[7]     = i_mstatus_mpie;
                o_cur_data[12:11] = 2'b11;  // mpp, machine mode only
            end
            A_MISA: o_cur_data = MISA_VALUE;
            A_MIE: begin
                o_cur_data[3]  = i_mie_msie;
                o_cur_data[7]  = i_mie_mtie;
                o_cur_data[11] = i_mie_meie;
            end
            A_MTVEC:    o_cur_data = i_mtvec;
            A_MSCRATCH: o_cur_data = i_mscratch;
            A_MEPC:     o_cur_data = i_mepc;
            A_MCAUSE: begin
                o_cur_data[31]  = i_mcause_int;
                o_cur_data[3:0] = i_mcause_code;
            end
            A_MTVAL:     o_cur_data = i_mtval;
            A_MCYCLE:    o_cur_data = i_cnt_cycle[CSR_XLEN-1:0];
            A_MCYCLEH:   o_cur_data = i_cnt_cycle[CNT_W-1:CSR_XLEN];
            A_MINSTRET:  o_cur_data = i_cnt_instret[CSR_XLEN-1:0];
            A_MINSTRETH: o_cur_data = i_cnt_instret[CNT_W-1:CSR_XLEN];
            A_MCOUNTINHIBIT: begin
                o_cur_data[0] = i_cnt_inhibit[CNT_CYCLE];    // cy
                o_cur_data[2] = i_cnt_inhibit[CNT_INSTRET];  // ir
            end
            default: o_cur_data = '0;  // unimplemented index
        endcase
    end

    // every request answers, with or without a write; rdata holds between requests
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_csr_rdata   <= '0;
            o_rdata_valid <= 1'b0;
        end else begin
            o_rdata_valid <= i_csr_valid;  // single-cycle pulse per request
            if (i_csr_valid)
                o_csr_rdata <= o_cur_data;  // sampled before the write lands
        end
    end

    // no request, no answer on the following cycle
    a_no_spurious_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_csr_valid |=> !o_rdata_valid)
        else $error("read valid without a request");

    // a request must carry a defined op and index, the decoder and mux both act on them
    a_req_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_csr_valid |-> !$isunknown({i_funct3, i_csr_index}))
        else $error("csr request with unknown op or index");

endmodule

//--- logic/csr_unit_top.sv
// machine csr access unit, one request per cycle, no back-pressure; traps and interrupts are outside
module csr_unit_top #(
    parameter logic [csr_pkg::CSR_XLEN-1:0] TRAP_ADDRESS = '0  // mtvec reset value
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_csr_valid,    // request strobe
    input  csr_pkg::csr_op_e               i_funct3,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] i_csr_index,
    input  logic [csr_pkg::CSR_XLEN-1:0]   i_rs1,
    input  logic [csr_pkg::CSR_XLEN-1:0]   i_imm,          // zero-extended uimm
    input  logic                           i_instret_inc,  // one instruction retired
    output logic [csr_pkg::CSR_XLEN-1:0]   o_csr_rdata,
    output logic                           o_rdata_valid
);
    import csr_pkg::*;

    logic [CSR_XLEN-1:0]    cur_data;
    logic [CSR_XLEN-1:0]    wr_data;
    logic [NUM_CFG_SEL-1:0] cfg_wr_sel;
    logic [NUM_CNT-1:0]     cnt_wr_lo;
    logic [NUM_CNT-1:0]     cnt_wr_hi;
    logic [NUM_CNT-1:0]     cnt_inhibit;
    logic [NUM_CNT-1:0]     cnt_inc;
    logic [CNT_W-1:0]       cnt_count [NUM_CNT];
    // config field values
    logic                   mstatus_mie, mstatus_mpie;
    logic                   mie_msie, mie_mtie, mie_meie;
    logic [CSR_XLEN-1:0]    mtvec, mscratch, mepc, mtval;
    logic                   mcause_int;
    logic [3:0]             mcause_code;

    assign cnt_inc[CNT_CYCLE]   = 1'b1;           // mcycle counts every clock
    assign cnt_inc[CNT_INSTRET] = i_instret_inc;

    csr_access_decode u_csr_access_decode (
        .i_csr_valid (i_csr_valid), .i_funct3 (i_funct3), .i_csr_index (i_csr_index),
        .i_rs1 (i_rs1), .i_imm (i_imm), .i_cur_data (cur_data),
        .o_cfg_wr_sel (cfg_wr_sel), .o_cnt_wr_lo (cnt_wr_lo), .o_cnt_wr_hi (cnt_wr_hi),
        .o_wr_data (wr_data)
    );

    csr_config_regs #(.TRAP_ADDRESS(TRAP_ADDRESS)) u_csr_config_regs (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_cfg_wr_sel (cfg_wr_sel), .i_wr_data (wr_data),
        .o_mstatus_mie (mstatus_mie), .o_mstatus_mpie (mstatus_mpie),
        .o_mie_msie (mie_msie), .o_mie_mtie (mie_mtie), .o_mie_meie (mie_meie),
        .o_mtvec (mtvec), .o_mscratch (mscratch), .o_mepc (mepc), .o_mtval (mtval),
        .o_mcause_int (mcause_int), .o_mcause_code (mcause_code), .o_cnt_inhibit (cnt_inhibit)
    );

    // mcycle and minstret share one counter design
    for (genvar g = 0; g < NUM_CNT; g++) begin : g_cnt
        hpm_counter u_hpm_counter (
            .i_clk (i_clk), .i_rst_n (i_rst_n), .i_inc (cnt_inc[g]), .i_inhibit (cnt_inhibit[g]),
            .i_wr_lo (cnt_wr_lo[g]), .i_wr_hi (cnt_wr_hi[g]), .i_wr_data (wr_data),
            .o_count (cnt_count[g])
        );
    end

    csr_read_mux u_csr_read_mux (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_csr_valid (i_csr_valid), .i_funct3 (i_funct3),
        .i_csr_index (i_csr_index),
        .i_mstatus_mie (mstatus_mie), .i_mstatus_mpie (mstatus_mpie),
        .i_mie_msie (mie_msie), .i_mie_mtie (mie_mtie), .i_mie_meie (mie_meie),
        .i_mtvec (mtvec), .i_mscratch (mscratch), .i_mepc (mepc), .i_mtval (mtval),
        .i_mcause_int (mcause_int), .i_mcause_code (mcause_code), .i_cnt_inhibit (cnt_inhibit),
        .i_cnt_cycle (cnt_count[CNT_CYCLE]), .i_cnt_instret (cnt_count[CNT_INSTRET]),
        .o_cur_data (cur_data), .o_csr_rdata (o_csr_rdata), .o_rdata_valid (o_rdata_valid)
    );

endmodule

//--- verification/csr_unit_tb.sv
// testbench for csr_unit_top; the shadow model assumes TRAP_ADDRESS 0x100 and a 5-bit uimm on i_imm
module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [CSR_XLEN-1:0] TRAP_ADDR = 32'h0000_0100;
    localparam int NUM_DIRECTED = 88;   // scripted directed requests
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_CYCLES   = 2 * (NUM_DIRECTED + NUM_RANDOM) + 100;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_csr_valid;
    csr_op_e               i_funct3;
    logic [CSR_ADDR_W-1:0] i_csr_index;
    logic [CSR_XLEN-1:0]   i_rs1;
    logic [CSR_XLEN-1:0]   i_imm;
    logic                  i_instret_inc;
    logic [CSR_XLEN-1:0]   o_csr_rdata;
    logic                  o_rdata_valid;

    integer                seed = 32'he517967f;
    int                    cycles = 0;
    logic [CSR_XLEN-1:0]   exp_q [$];  // expected read data in request order
    logic [CSR_ADDR_W-1:0] idx_q [$];  // index of each pending read
    logic [CSR_ADDR_W-1:0] kept_idx [18] = '{A_MVENDORID, A_MARCHID, A_MIMPID, A_MHARTID,
        A_MSTATUS, A_MISA, A_MIE, A_MTVEC, A_MSCRATCH, A_MEPC, A_MCAUSE, A_MTVAL,
        A_MCYCLE, A_MCYCLEH, A_MINSTRET, A_MINSTRETH, A_MCOUNTINHIBIT, 12'h7C0};

    // shadow of the architectural state
    logic sh_mie, sh_mpie, sh_msie, sh_mtie, sh_meie, sh_mcause_int, sh_cy, sh_ir;
    logic [3:0]          sh_mcause_code;
    logic [CSR_XLEN-1:0] sh_mtvec, sh_mscratch, sh_mepc, sh_mtval;
    logic [CNT_W-1:0]    sh_cycle, sh_instret;

    csr_unit_top #(.TRAP_ADDRESS(TRAP_ADDR)) u_csr_unit_top (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_csr_valid (i_csr_valid), .i_funct3 (i_funct3),
        .i_csr_index (i_csr_index), .i_rs1 (i_rs1), .i_imm (i_imm),
        .i_instret_inc (i_instret_inc), .o_csr_rdata (o_csr_rdata),
        .o_rdata_valid (o_rdata_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // architectural read word of the shadow state
    function automatic logic [CSR_XLEN-1:0] ref_read(input logic [CSR_ADDR_W-1:0] idx);
        logic [CSR_XLEN-1:0] w;
        w = '0;  // info regs and unknown indices
        case (idx)
            A_MSTATUS: begin
                w[12:11] = 2'b11;  // mpp machine
                w[7]     = sh_mpie;
                w[3]     = sh_mie;
            end
            A_MISA: begin
                w[31:30] = 2'b01;  // mxl 32
                w[8]     = 1'b1;   // I
            end
            A_MIE: w = {20'b0, sh_meie, 3'b0, sh_mtie, 3'b0, sh_msie, 3'b0};
            A_MTVEC:         w = sh_mtvec;
            A_MSCRATCH:      w = sh_mscratch;
            A_MEPC:          w = sh_mepc;
            A_MCAUSE:        w = {sh_mcause_int, 27'b0, sh_mcause_code};
            A_MTVAL:         w = sh_mtval;
            A_MCYCLE:        w = sh_cycle[31:0];
            A_MCYCLEH:       w = sh_cycle[63:32];
            A_MINSTRET:      w = sh_instret[31:0];
            A_MINSTRETH:     w = sh_instret[63:32];
            A_MCOUNTINHIBIT: w = {29'b0, sh_ir, 1'b0, sh_cy};
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic [CSR_XLEN-1:0] combine(input csr_op_e op,
                                                    input logic [CSR_XLEN-1:0] old,
                                                    input logic [CSR_XLEN-1:0] src);
        case (op)
            OP_RW, OP_RWI: return src;
            OP_RS, OP_RSI: return old | src;
            default:       return old & ~src;  // clear forms
        endcase
    endfunction

    // a half write wins over the count event
    function automatic logic [CNT_W-1:0] next_count(input logic [CNT_W-1:0] old, input logic inc,
                                                     input logic wr_lo, input logic wr_hi,
                                                     input logic [CSR_XLEN-1:0] data);
        logic [CNT_W-1:0] n;
        n = old;
        if (wr_lo)
            n[31:0] = data;
        if (wr_hi)
            n[63:32] = data;
        if (!wr_lo && !wr_hi && inc)
            n = old + 1;
        return n;
    endfunction

    task automatic write_shadow(input logic [CSR_ADDR_W-1:0] idx, input logic [CSR_XLEN-1:0] v);
        case (idx)
            A_MSTATUS:       {sh_mpie, sh_mie} = {v[7], v[3]};
            A_MIE:           {sh_meie, sh_mtie, sh_msie} = {v[11], v[7], v[3]};
            A_MTVEC:         sh_mtvec = v;
            A_MSCRATCH:      sh_mscratch = v;
            A_MEPC:          sh_mepc = {v[31:2], 2'b00};  // word aligned
            A_MCAUSE:        {sh_mcause_int, sh_mcause_code} = {v[31], v[3:0]};
            A_MTVAL:         sh_mtval = v;
            A_MCOUNTINHIBIT: {sh_ir, sh_cy} = {v[2], v[0]};
            default: ;       // counters step elsewhere and read-only or unknown indices ignore writes
        endcase
    endtask

    task automatic check_value(input logic [CSR_XLEN-1:0] got, input logic [CSR_XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // check the response before the model takes the request sampled at this edge
    always @(posedge i_clk) begin : model_and_compare
        logic [CSR_XLEN-1:0] old_val;
        logic [CSR_XLEN-1:0] new_val;
        logic                wr_ok;
        if (o_rdata_valid && exp_q.size() == 0) begin
            $display("read valid at %0t without a pending request", $time);
            $display("ERRORS FOUND");
            $fatal(1, "unexpected response");
        end else if (o_rdata_valid) begin
            check_value(o_csr_rdata, exp_q.pop_front(), $sformatf("csr %h", idx_q.pop_front()));
        end
        old_val = ref_read(i_csr_index);
        new_val = combine(i_funct3, old_val, i_funct3[2] ? i_imm : i_rs1);
        wr_ok   = i_csr_valid && i_funct3 != 3'b000 && i_funct3 != 3'b100;
        if (!i_rst_n) begin
            {sh_mie, sh_mpie, sh_msie, sh_mtie, sh_meie, sh_mcause_int, sh_cy, sh_ir} = '0;
            {sh_mcause_code, sh_mscratch, sh_mepc, sh_mtval, sh_cycle, sh_instret} = '0;
            sh_mtvec = TRAP_ADDR;
        end else begin
            if (i_csr_valid) begin  // illegal ops still answer
                exp_q.push_back(old_val);
                idx_q.push_back(i_csr_index);
            end
            sh_cycle   = next_count(sh_cycle, !sh_cy, wr_ok && i_csr_index == A_MCYCLE,
                                    wr_ok && i_csr_index == A_MCYCLEH, new_val);
            sh_instret = next_count(sh_instret, i_instret_inc && !sh_ir,
                                    wr_ok && i_csr_index == A_MINSTRET,
                                    wr_ok && i_csr_index == A_MINSTRETH, new_val);
            if (wr_ok)
                write_shadow(i_csr_index, new_val);
        end
    end

    always @(posedge i_clk) begin : watchdog
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    function automatic logic rand_bit();
        integer r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic access(input csr_op_e op, input logic [CSR_ADDR_W-1:0] idx,
                          input logic [CSR_XLEN-1:0] src);
        @(posedge i_clk);
        i_csr_valid   <= 1'b1;
        i_funct3      <= op;
        i_csr_index   <= idx;
        i_rs1         <= src;
        i_imm         <= {27'b0, src[4:0]};  // uimm field
        i_instret_inc <= rand_bit();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge i_clk);
            i_csr_valid   <= 1'b0;
            i_instret_inc <= rand_bit();
        end
    endtask

    task automatic read_csr(input logic [CSR_ADDR_W-1:0] idx);
        access(OP_RS, idx, '0);  // set with zero source changes nothing
    endtask

    initial begin : stimulus
        integer                r;
        logic [CSR_ADDR_W-1:0] idx;
        logic [CSR_ADDR_W-1:0] mask_idx [8];
        mask_idx      = '{A_MSTATUS, A_MIE, A_MCAUSE, A_MCOUNTINHIBIT,
                          A_MEPC, A_MISA, A_MVENDORID, 12'h7C0};
        i_rst_n       = 1'b0;
        i_csr_valid   = 1'b0;
        i_funct3      = OP_RW;
        i_csr_index   = '0;
        i_rs1         = '0;
        i_imm         = '0;
        i_instret_inc = 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        check_value({31'b0, o_rdata_valid}, 32'h0, "read valid after reset");
        check_value(o_csr_rdata, 32'h0, "read data after reset");
        // reset values
        read_csr(A_MISA);
        read_csr(A_MTVEC);
        read_csr(A_MSTATUS);
        read_csr(A_MVENDORID);
        read_csr(A_MARCHID);
        read_csr(A_MIMPID);
        read_csr(A_MHARTID);
        // old value then new value over all six ops
        for (int k = 0; k < 2; k++) begin
            idx = k ? A_MTVAL : A_MSCRATCH;
            access(OP_RW, idx, 32'hdead_beef);
            access(OP_RWI, idx, 32'h15);
            read_csr(idx);
            access(OP_RS, idx, 32'hf0f0_0000);
            access(OP_RC, idx, 32'h0000_0014);
            access(OP_RSI, idx, 32'h0a);
            access(OP_RCI, idx, 32'h02);
        end
        // field masking plus read-only and unknown indices
        foreach (mask_idx[k]) begin
            access(OP_RS, mask_idx[k], 32'hffff_ffff);
            read_csr(mask_idx[k]);
            access(OP_RC, mask_idx[k], 32'h8000_0808);
            read_csr(mask_idx[k]);
            access(OP_RW, mask_idx[k], 32'h0000_1237);
            read_csr(mask_idx[k]);
        end
        // mcycle counting with inhibit and half loads across a carry
        access(OP_RW, A_MCOUNTINHIBIT, 32'h0);
        read_csr(A_MCYCLE);
        idle(4);
        read_csr(A_MCYCLE);
        access(OP_RSI, A_MCOUNTINHIBIT, 32'h1);
        idle(4);
        read_csr(A_MCYCLE);
        read_csr(A_MCYCLE);
        access(OP_RCI, A_MCOUNTINHIBIT, 32'h1);
        access(OP_RW, A_MCYCLEH, 32'h1);
        access(OP_RW, A_MCYCLE, 32'hffff_fff8);
        idle(12);
        read_csr(A_MCYCLE);
        read_csr(A_MCYCLEH);
        // minstret counting follows i_instret_inc
        access(OP_RW, A_MINSTRETH, 32'h2);
        access(OP_RW, A_MINSTRET, 32'hffff_fffc);
        idle(10);
        read_csr(A_MINSTRET);
        read_csr(A_MINSTRETH);
        access(OP_RSI, A_MCOUNTINHIBIT, 32'h4);
        idle(6);
        read_csr(A_MINSTRET);
        access(OP_RCI, A_MCOUNTINHIBIT, 32'h4);
        read_csr(A_MINSTRET);
        // random traffic where funct3 0 and 4 answer without a write
        repeat (NUM_RANDOM) begin
            r = $random(seed);
            access(csr_op_e'(r[2:0]), kept_idx[r[7:3] % 18], $random(seed));
        end
        idle(3);
        if (exp_q.size() != 0) begin
            $display("%0d read responses never arrived", exp_q.size());
            $display("ERRORS FOUND");
            $fatal(1, "missing responses");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- filelist.f
logic/csr_pkg.sv
logic/csr_access_decode.sv
logic/csr_config_regs.sv
logic/hpm_counter.sv
logic/csr_read_mux.sv
logic/csr_unit_top.sv
verification/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - logic/csr_pkg.sv
  - logic/csr_access_decode.sv
  - logic/csr_config_regs.sv
  - logic/hpm_counter.sv
  - logic/csr_read_mux.sv
  - logic/csr_unit_top.sv
  - target: test
    files:
      - verification/csr_unit_tb.sv
